// ==== verilog/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths fixed by the RV32I ISA.
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_NUM_W = $clog2(NUM_REGS);
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_NUM_W-1:0] reg_num_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;

    // major opcodes of RV32I.
    // NONE is not an ISA encoding, it marks a bubble or an unknown opcode.
    typedef enum logic [OPCODE_W-1:0] {
        NONE   = 7'b0000000,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_e;

    // funct3 codes of the conditional branches.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    //////////////////////////////////////////////////////////////////////
    // bundles between decode and its neighbors.
    //////////////////////////////////////////////////////////////////////

    // what decode hands to execute each cycle.
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_num_t rd;
        opcode_e  opcode;
        funct3_t  funct3;
        funct7_t  funct7;
    } id_ex_t;

    // redirect request for fetch.
    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    // an all-zero bundle is a bubble, since NONE encodes as zero.
    localparam id_ex_t  ID_EX_BUBBLE     = '0;
    localparam branch_t BRANCH_NOT_TAKEN = '0;

endpackage

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none

module register_file (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  rv_decode_pkg::reg_num_t i_rs1_num,
    input  rv_decode_pkg::reg_num_t i_rs2_num,
    input  wire                    i_wr_en,
    input  rv_decode_pkg::reg_num_t i_wr_num,
    input  rv_decode_pkg::word_t    i_wr_data,
    output rv_decode_pkg::word_t    o_rs1_val,
    output rv_decode_pkg::word_t    o_rs2_val
);

    import rv_decode_pkg::*;

    // register zero has no storage behind it.
    word_t regs [1:NUM_REGS-1];

    logic wr_hit;

    // a write to register zero is dropped here, so it never reaches the array.
    assign wr_hit = i_wr_en && (i_wr_num != '0);

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[i_wr_num] <= i_wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // one read port.
    // A write to the same register in this cycle is passed straight through,
    // so writeback and decode may touch the same register without a stall.
    function automatic word_t read_port(input reg_num_t num);
        word_t val;
        if (num == '0) begin
            val = '0;
        end else if (wr_hit && (i_wr_num == num)) begin
            val = i_wr_data;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1_num);
        o_rs2_val = read_port(i_rs2_num);
    end

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`default_nettype none

module branch_unit (
    input  rv_decode_pkg::word_t   i_pc,
    input  rv_decode_pkg::opcode_e i_opcode,
    input  rv_decode_pkg::funct3_t i_funct3,
    input  rv_decode_pkg::word_t   i_rs1_val,
    input  rv_decode_pkg::word_t   i_rs2_val,
    input  rv_decode_pkg::word_t   i_imm,
    output rv_decode_pkg::branch_t o_branch
);

    import rv_decode_pkg::*;

    logic  rs_eq;
    logic  rs_lt;
    logic  rs_ltu;
    logic  cond_met;
    word_t pc_rel_target;
    word_t reg_rel_target;

    //////////////////////////////////////////////////////////////////////
    // operand compares
    //////////////////////////////////////////////////////////////////////

    // the three compares cover all six conditions, the others are inverses.
    assign rs_eq  = (i_rs1_val == i_rs2_val);
    assign rs_lt  = ($signed(i_rs1_val) < $signed(i_rs2_val));
    assign rs_ltu = (i_rs1_val < i_rs2_val);

    always_comb begin
        case (i_funct3)
            F3_BEQ:  cond_met = rs_eq;
            F3_BNE:  cond_met = !rs_eq;
            F3_BLT:  cond_met = rs_lt;
            F3_BGE:  cond_met = !rs_lt;
            F3_BLTU: cond_met = rs_ltu;
            F3_BGEU: cond_met = !rs_ltu;
            // codes 010 and 011 are reserved and never branch.
            default: cond_met = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // targets
    //////////////////////////////////////////////////////////////////////

    // branches and JAL are relative to the instruction's own pc.
    assign pc_rel_target = i_pc + i_imm;

    // JALR drops bit 0 of the sum, as the ISA requires.
    assign reg_rel_target = (i_rs1_val + i_imm) & ~word_t'(1);

    always_comb begin
        o_branch = BRANCH_NOT_TAKEN;
        case (i_opcode)
            BRANCH: begin
                o_branch.taken  = cond_met;
                o_branch.target = pc_rel_target;
            end
            JAL: begin
                o_branch.taken  = 1'b1;
                o_branch.target = pc_rel_target;
            end
            JALR: begin
                o_branch.taken  = 1'b1;
                o_branch.target = reg_rel_target;
            end
            default: begin
                o_branch = BRANCH_NOT_TAKEN;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/data_hazard_unit.sv ====
`default_nettype none

module data_hazard_unit (
    input  rv_decode_pkg::opcode_e  i_opcode,
    input  rv_decode_pkg::reg_num_t i_rs1_num,
    input  rv_decode_pkg::reg_num_t i_rs2_num,
    input  rv_decode_pkg::reg_num_t i_id_ex_rd,
    input  rv_decode_pkg::reg_num_t i_ex_mem_rd,
    output logic                    o_stall
);

    import rv_decode_pkg::*;

    logic uses_rs1;
    logic uses_rs2;
    logic rs1_busy;
    logic rs2_busy;

    // which source fields are real operands for this format.
    // For I-type and U-type the rs2 bits belong to the immediate.
    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (i_opcode)
            JALR, LOAD, OP_IMM: begin
                uses_rs1 = 1'b1;
            end
            BRANCH, STORE, OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: begin
                uses_rs1 = 1'b0;
                uses_rs2 = 1'b0;
            end
        endcase
    end

    // register zero is never a hazard. A younger stage with no result
    // presents zero, so it can never match a busy source either.
    always_comb begin
        rs1_busy = (i_rs1_num != '0) &&
                   ((i_rs1_num == i_id_ex_rd) || (i_rs1_num == i_ex_mem_rd));
        rs2_busy = (i_rs2_num != '0) &&
                   ((i_rs2_num == i_id_ex_rd) || (i_rs2_num == i_ex_mem_rd));
    end

    // there is no forwarding, so the instruction waits for writeback.
    // This also covers branches, which need final operands in decode.
    assign o_stall = (uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy);

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  rv_decode_pkg::word_t    i_inst,
    input  rv_decode_pkg::word_t    i_pc,
    input  wire                     i_wb_en,
    input  rv_decode_pkg::reg_num_t i_wb_rd,
    input  rv_decode_pkg::word_t    i_wb_data,
    input  rv_decode_pkg::reg_num_t i_id_ex_rd,
    input  rv_decode_pkg::reg_num_t i_ex_mem_rd,
    output logic                    o_stall,
    output rv_decode_pkg::branch_t  o_branch,
    output rv_decode_pkg::id_ex_t   o_id_ex
);

    import rv_decode_pkg::*;

    logic [OPCODE_W-1:0] opcode_raw;
    opcode_e             opcode;
    reg_num_t            rd_num;
    reg_num_t            rs1_num;
    reg_num_t            rs2_num;
    funct3_t             funct3;
    funct7_t             funct7;
    word_t               imm;
    word_t               rs1_val;
    word_t               rs2_val;
    branch_t             branch_raw;
    id_ex_t              id_ex_next;

    //////////////////////////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////////////////////////

    assign opcode_raw = i_inst[6:0];
    assign rd_num     = i_inst[11:7];
    assign funct3     = i_inst[14:12];
    assign rs1_num    = i_inst[19:15];
    assign rs2_num    = i_inst[24:20];
    assign funct7     = i_inst[31:25];

    // only the nine RV32I major opcodes pass through.
    // Anything else becomes NONE and is treated like a bubble downstream.
    always_comb begin
        case (opcode_raw)
            LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP: begin
                opcode = opcode_e'(opcode_raw);
            end
            default: begin
                opcode = NONE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // immediate generation
    //////////////////////////////////////////////////////////////////////

    // bit 31 of the instruction is always the sign bit of the immediate.
    always_comb begin
        case (opcode)
            JALR, LOAD, OP_IMM: begin
                imm = {{20{i_inst[31]}}, i_inst[31:20]};
            end
            STORE: begin
                imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            end
            BRANCH: begin
                imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                       i_inst[30:25], i_inst[11:8], 1'b0};
            end
            LUI, AUIPC: begin
                imm = {i_inst[31:12], 12'b0};
            end
            JAL: begin
                imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                       i_inst[20], i_inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // units
    //////////////////////////////////////////////////////////////////////

    register_file register_file_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs1_num (rs1_num),
        .i_rs2_num (rs2_num),
        .i_wr_en   (i_wb_en),
        .i_wr_num  (i_wb_rd),
        .i_wr_data (i_wb_data),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    branch_unit branch_unit_inst (
        .i_pc      (i_pc),
        .i_opcode  (opcode),
        .i_funct3  (funct3),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .i_imm     (imm),
        .o_branch  (branch_raw)
    );

    data_hazard_unit data_hazard_unit_inst (
        .i_opcode    (opcode),
        .i_rs1_num   (rs1_num),
        .i_rs2_num   (rs2_num),
        .i_id_ex_rd  (i_id_ex_rd),
        .i_ex_mem_rd (i_ex_mem_rd),
        .o_stall     (o_stall)
    );

    // operands read during a stall are stale, so no redirect may leave.
    // fetch sees the branch again once the hazard clears.
    assign o_branch = o_stall ? BRANCH_NOT_TAKEN : branch_raw;

    //////////////////////////////////////////////////////////////////////
    // ID/EX pipeline register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        id_ex_next.valid   = (opcode != NONE);
        id_ex_next.pc      = i_pc;
        id_ex_next.rs1_val = rs1_val;
        id_ex_next.rs2_val = rs2_val;
        id_ex_next.imm     = imm;
        id_ex_next.rd      = rd_num;
        id_ex_next.opcode  = opcode;
        id_ex_next.funct3  = funct3;
        id_ex_next.funct7  = funct7;
    end

    // a stalled cycle sends a bubble to execute.
    // The held instruction is captured in the first cycle without a stall.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= ID_EX_BUBBLE;
        end else if (o_stall) begin
            o_id_ex <= ID_EX_BUBBLE;
        end else begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

// ==== tb/decode_stage_assertions.sv ====
`default_nettype none

module decode_stage_assertions (
    input wire                    i_clk,
    input wire                    i_rst_n,
    input wire                    i_stall,
    input rv_decode_pkg::branch_t i_branch,
    input rv_decode_pkg::id_ex_t  i_id_ex
);

    int failures = 0;

    // a stalled cycle captures a bubble at the next edge.
    stall_inserts_bubble: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_stall |=> !i_id_ex.valid
    ) else begin
        failures++;
        $error("a stall was not followed by a bubble in o_id_ex");
    end

    stall_blocks_branch: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_stall |-> !i_branch.taken
    ) else begin
        failures++;
        $error("o_branch was taken during a stall");
    end

    reset_gives_bubble: assert property (
        @(posedge i_clk) !i_rst_n |-> !i_id_ex.valid
    ) else begin
        failures++;
        $error("o_id_ex was valid during reset");
    end

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_stall  (o_stall),
    .i_branch (o_branch),
    .i_id_ex  (o_id_ex)
);

`default_nettype wire

// ==== tb/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb;

    import rv_decode_pkg::*;

    // about 430 cycles of stimulus, rounded up, with a wide margin.
    localparam int TEST_CYCLES = 500;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

    // the widest compared value is the whole ID/EX bundle.
    localparam int CMP_W = $bits(id_ex_t);

    typedef struct packed {
        logic    stall;
        branch_t branch;
        id_ex_t  id_ex;
    } expect_t;

    logic     i_clk;
    logic     i_rst_n;
    word_t    i_inst;
    word_t    i_pc;
    logic     i_wb_en;
    reg_num_t i_wb_rd;
    word_t    i_wb_data;
    reg_num_t i_id_ex_rd;
    reg_num_t i_ex_mem_rd;
    logic     o_stall;
    branch_t  o_branch;
    id_ex_t   o_id_ex;

    word_t       shadow [NUM_REGS];
    expect_t     expected;
    logic        check_en;
    logic [15:0] lfsr_state;
    int          cycles;
    int          passes;
    int          errors;
    int          test_errors;

    decode_stage decode_stage_inst (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit.
    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t random_pc();
        word_t v;
        v = random_bits(32);
        return {v[31:2], 2'b00};
    endfunction

    // one of the nine major opcodes with random upper bits.
    function automatic word_t random_inst();
        opcode_e op;
        word_t   r;
        case (random_bits(8) % 9)
            0: op = LUI;
            1: op = AUIPC;
            2: op = JAL;
            3: op = JALR;
            4: op = BRANCH;
            5: op = LOAD;
            6: op = STORE;
            7: op = OP_IMM;
            default: op = OP;
        endcase
        r = random_bits(25);
        return {r[24:0], op};
    endfunction

    function automatic word_t op_inst(input reg_num_t rs2, input reg_num_t rs1,
                                      input reg_num_t rd);
        return {7'b0, rs2, rs1, 3'b000, rd, OP};
    endfunction

    function automatic word_t branch_inst(input funct3_t f3, input reg_num_t rs1,
                                          input reg_num_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t jal_inst(input logic [20:0] off, input reg_num_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic word_t jalr_inst(input logic [11:0] off, input reg_num_t rs1,
                                        input reg_num_t rd);
        return {off, rs1, 3'b000, rd, JALR};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // expected stall, redirect and next bundle for one set of inputs.
    // a and b are the shadow values of the two source registers.
    function automatic expect_t reference(input word_t inst, input word_t pc,
                                          input word_t a, input word_t b,
                                          input reg_num_t ex_rd, input reg_num_t mem_rd);
        expect_t            e;
        opcode_e            op;
        logic signed [31:0] sx;
        word_t              imm;
        reg_num_t           r1;
        reg_num_t           r2;
        logic               use1;
        logic               use2;
        logic               cond;
        e  = '0;
        r1 = inst[19:15];
        r2 = inst[24:20];
        op = opcode_e'(inst[6:0]);
        if (!(op inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP})) begin
            op = NONE;
        end
        // the immediate bits are packed at the top and shifted down with sign.
        case (op)
            JALR, LOAD, OP_IMM: begin
                sx  = inst;
                imm = sx >>> 20;
            end
            STORE: begin
                sx  = {inst[31:25], inst[11:7], 20'b0};
                imm = sx >>> 20;
            end
            BRANCH: begin
                sx  = {inst[31], inst[7], inst[30:25], inst[11:8], 20'b0};
                imm = sx >>> 19;
            end
            JAL: begin
                sx  = {inst[31], inst[19:12], inst[20], inst[30:21], 12'b0};
                imm = sx >>> 11;
            end
            LUI, AUIPC: imm = inst & 32'hffff_f000;
            default: imm = '0;
        endcase
        case (inst[14:12])
            3'b000: cond = (a == b);
            3'b001: cond = (a != b);
            3'b100: cond = ($signed(a) < $signed(b));
            3'b101: cond = ($signed(a) >= $signed(b));
            3'b110: cond = (a < b);
            3'b111: cond = (a >= b);
            default: cond = 1'b0;
        endcase
        if (op == BRANCH) begin
            e.branch = {cond, pc + imm};
        end else if (op == JAL) begin
            e.branch = {1'b1, pc + imm};
        end else if (op == JALR) begin
            e.branch = {1'b1, (a + imm) & 32'hffff_fffe};
        end
        use1 = op inside {JALR, BRANCH, LOAD, STORE, OP_IMM, OP};
        use2 = op inside {BRANCH, STORE, OP};
        e.stall = (use1 && r1 != 0 && (r1 == ex_rd || r1 == mem_rd)) ||
                  (use2 && r2 != 0 && (r2 == ex_rd || r2 == mem_rd));
        if (e.stall) begin
            e.branch = '0;
        end else begin
            e.id_ex = {op != NONE, pc, a, b, imm, inst[11:7], op, inst[14:12],
                       inst[31:25]};
        end
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // driving and checking
    //////////////////////////////////////////////////////////////////////

    // inputs change on the falling edge and the expected response follows.
    task automatic apply(input word_t inst, input word_t pc, input logic wb_en,
                         input reg_num_t wb_rd, input word_t wb_data,
                         input reg_num_t ex_rd, input reg_num_t mem_rd);
        @(negedge i_clk);
        i_inst      = inst;
        i_pc        = pc;
        i_wb_en     = wb_en;
        i_wb_rd     = wb_rd;
        i_wb_data   = wb_data;
        i_id_ex_rd  = ex_rd;
        i_ex_mem_rd = mem_rd;
        // the write is visible to decode in the same cycle.
        if (wb_en && wb_rd != 0) begin
            shadow[wb_rd] = wb_data;
        end
        expected = reference(inst, pc, shadow[inst[19:15]], shadow[inst[24:20]],
                             ex_rd, mem_rd);
    endtask

    task automatic compare(input string name, input logic [CMP_W-1:0] exp,
                           input logic [CMP_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end else begin
            passes++;
        end
    endtask

    task automatic end_test(input string name);
        @(posedge i_clk);
        #2;
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    always begin
        @(negedge i_clk);
        #4;
        if (check_en) begin
            compare("o_stall", expected.stall, o_stall);
            compare("o_branch", expected.branch, o_branch);
        end
        @(posedge i_clk);
        #1;
        if (check_en) begin
            compare("o_id_ex", expected.id_ex, o_id_ex);
        end
    end

    initial begin
        reg_num_t rn;
        word_t    inst;
        i_clk = 1'b0;
        i_rst_n = 1'b1;
        i_inst = '0;
        i_pc = '0;
        i_wb_en = 1'b0;
        i_wb_rd = '0;
        i_wb_data = '0;
        i_id_ex_rd = '0;
        i_ex_mem_rd = '0;
        lfsr_state = 16'd9934;
        cycles = 0;
        passes = 0;
        errors = 0;
        test_errors = 0;
        expected = '0;
        check_en = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        #1;
        i_rst_n = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_en = 1'b1;
        compare("o_id_ex after reset", '0, o_id_ex);

        for (int r = 1; r < NUM_REGS; r++) begin
            apply('0, '0, 1'b1, reg_num_t'(r), random_bits(32), '0, '0);
        end
        apply('0, '0, 1'b1, 5'd0, random_bits(32), '0, '0);
        for (int r = 0; r < NUM_REGS; r += 2) begin
            apply(op_inst(reg_num_t'(r + 1), reg_num_t'(r), 5'd1), random_pc(), 1'b0,
                  '0, '0, '0, '0);
        end
        end_test("reset and register file");

        for (int k = 0; k < 8; k++) begin
            rn = reg_num_t'(random_bits(5));
            if (rn == 0) begin
                rn = 5'd1;
            end
            apply(op_inst(rn, rn, 5'd2), random_pc(), 1'b1, rn, random_bits(32), '0, '0);
        end
        end_test("write-through bypass");

        for (int k = 0; k < 200; k++) begin
            apply(random_inst(), random_pc(), 1'b0, '0, '0, '0, '0);
        end
        end_test("field and immediate decoding");

        // signed and unsigned edge values in x2 to x5.
        apply('0, '0, 1'b1, 5'd2, 32'h8000_0000, '0, '0);
        apply('0, '0, 1'b1, 5'd3, 32'h7fff_ffff, '0, '0);
        apply('0, '0, 1'b1, 5'd4, 32'hffff_ffff, '0, '0);
        apply('0, '0, 1'b1, 5'd5, 32'h0000_0001, '0, '0);
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 16; p++) begin
                if (f != 2 && f != 3) begin
                    apply(branch_inst(funct3_t'(f), reg_num_t'(2 + p / 4),
                                      reg_num_t'(2 + p % 4), random_bits(13)),
                          random_pc(), 1'b0, '0, '0, '0, '0);
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            apply(jal_inst(random_bits(21), 5'd1), random_pc(), 1'b0, '0, '0, '0, '0);
            apply(jalr_inst(random_bits(12) & 12'hffe, reg_num_t'(4 + k % 2), 5'd1),
                  random_pc(), 1'b0, '0, '0, '0, '0);
        end
        end_test("branch resolution");

        for (int k = 0; k < 40; k++) begin
            inst = random_inst();
            case (random_bits(2))
                0: apply(inst, random_pc(), 1'b0, '0, '0, inst[19:15], '0);
                1: apply(inst, random_pc(), 1'b0, '0, '0, '0, inst[24:20]);
                2: apply(inst, random_pc(), 1'b0, '0, '0, '0, '0);
                default: apply(inst, random_pc(), 1'b0, '0, '0, reg_num_t'(random_bits(5)),
                               reg_num_t'(random_bits(5)));
            endcase
        end
        // an instruction held through two stalls, then delivered.
        inst = op_inst(5'd7, 5'd6, 5'd8);
        apply(inst, 32'h100, 1'b0, '0, '0, 5'd6, '0);
        apply(inst, 32'h100, 1'b0, '0, '0, '0, 5'd7);
        apply(inst, 32'h100, 1'b0, '0, '0, '0, '0);
        apply(op_inst(5'd0, 5'd0, 5'd1), 32'h104, 1'b0, '0, '0, '0, '0);
        // the rs2 field of JALR belongs to the immediate.
        apply(jalr_inst(12'h007, 5'd6, 5'd1), 32'h108, 1'b0, '0, '0, 5'd7, 5'd7);
        apply('0, '0, 1'b0, '0, '0, '0, '0);
        end_test("hazard stall");

        errors += decode_stage_inst.decode_stage_assertions_inst.failures;
        $display("checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/rv_decode_pkg.sv
verilog/register_file.sv
verilog/branch_unit.sv
verilog/data_hazard_unit.sv
verilog/decode_stage.sv
tb/decode_stage_assertions.sv
tb/decode_stage_tb.sv
